// ==== logic/icache_pkg.sv ====
// Instruction-cache bank package with address split, line and way types, and controller states
`default_nettype none

package icache_pkg;

   //////////////////////////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////////////////////////

   // Fetch address and line width
   localparam int ADDR_WIDTH  = 32;
   localparam int LINE_WIDTH  = 128;

   // Address split as tag | set | byte offset
   localparam int LINE_OFFSET = 4;
   localparam int SET_BITS    = 4;
   localparam int NB_WAYS     = 4;
   localparam int TAG_BITS    = ADDR_WIDTH - SET_BITS - LINE_OFFSET;

   //////////////////////////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////////////////////////

   typedef logic [ADDR_WIDTH-1:0] fetch_addr_t;
   typedef logic [LINE_WIDTH-1:0] line_data_t;
   typedef logic [SET_BITS-1:0]   set_idx_t;
   typedef logic [TAG_BITS-1:0]   tag_t;

   // Stored tag word, valid bit on top
   typedef logic [TAG_BITS:0]     tag_entry_t;

   // One bit per way (hit, valid and victim masks)
   typedef logic [NB_WAYS-1:0]    way_mask_t;

   // Bank controller states
   typedef enum logic [1:0] {
      LOOKUP,
      REQ_REFILL,
      WAIT_REFILL
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/tag_compare.sv ====
// Tag compare over all ways, with valid mask and hit-line select
`default_nettype none

module tag_compare import icache_pkg::*;
(
   input  wire fetch_addr_t              lookup_addr_i,
   input  wire tag_entry_t [NB_WAYS-1:0] tag_rdata_i,
   input  wire line_data_t [NB_WAYS-1:0] data_rdata_i,
   output      logic                     hit_o,
   output      line_data_t               hit_line_o,
   output      way_mask_t                valid_o
);

   tag_t      lookup_tag;
   way_mask_t way_match;

   // Tag sits above set index and offset
   assign lookup_tag = lookup_addr_i[ADDR_WIDTH-1 -: TAG_BITS];

   // Valid bit and tag check per way
   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_way
      assign valid_o[w]   = tag_rdata_i[w][TAG_BITS];
      assign way_match[w] = valid_o[w] & (tag_rdata_i[w][TAG_BITS-1:0] == lookup_tag);
   end

   assign hit_o = |way_match;

   // Highest matching way wins
   always_comb
   begin
      hit_line_o = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (way_match[w])
            hit_line_o = data_rdata_i[w];
      end
   end

endmodule

`default_nettype wire

// ==== logic/victim_select.sv ====
// Victim way select, highest invalid way first, else a way from an 8-bit LFSR
`default_nettype none

module victim_select import icache_pkg::*;
#(
   parameter logic [7:0] LFSR_SEED = 8'h00
)
(
   input  wire logic      clk,
   input  wire logic      rst_n,
   input  wire way_mask_t valid_i,
   input  wire logic      save_valid_i,
   input  wire logic      advance_lfsr_i,
   output      way_mask_t victim_way_o
);

   way_mask_t  valid_q;
   logic [7:0] lfsr_q;
   logic       lfsr_fb;
   way_mask_t  free_way;
   way_mask_t  rand_way;

   // XNOR taps 8,6,5,4, so an all-zero seed still runs
   assign lfsr_fb = ~(lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= '0;
         lfsr_q  <= LFSR_SEED;
      end
      else
      begin
         // Valid mask of the set that missed
         if (save_valid_i)
            valid_q <= valid_i;
         // Step only when a full set is evicted
         if (advance_lfsr_i && (&valid_q))
            lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
   end

   always_comb
   begin
      free_way = '0;
      rand_way = '0;
      // Last invalid way found is the highest
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (!valid_q[w])
         begin
            free_way    = '0;
            free_way[w] = 1'b1;
         end
      end
      rand_way[lfsr_q[$clog2(NB_WAYS)-1:0]] = 1'b1;
   end

   assign victim_way_o = (&valid_q) ? rand_way : free_way;

endmodule

`default_nettype wire

// ==== logic/miss_buffer.sv ====
// Miss buffer, small request/grant FIFO of refill address and way
`default_nettype none

module miss_buffer import icache_pkg::*;
#(
   parameter int unsigned BUF_DEPTH = 2
)
(
   input  wire logic        clk,
   input  wire logic        rst_n,

   // Push side from the controller
   input  wire logic        push_i,
   input  wire fetch_addr_t push_addr_i,
   input  wire way_mask_t   push_way_i,
   output      logic        push_gnt_o,

   // Pop side toward the main controller
   output      logic        req_o,
   output      fetch_addr_t addr_o,
   output      way_mask_t   way_o,
   input  wire logic        pop_gnt_i
);

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   fetch_addr_t            addr_mem [BUF_DEPTH];
   way_mask_t              way_mem  [BUF_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       count;
   logic                   do_push;
   logic                   do_pop;

   assign push_gnt_o = (count != CNT_W'(BUF_DEPTH));
   assign req_o      = (count != '0);
   assign do_push    = push_i & push_gnt_o;
   assign do_pop     = req_o & pop_gnt_i;

   // Head entry held until granted
   assign addr_o = addr_mem[rd_ptr];
   assign way_o  = way_mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // Count moves only when one side acts alone
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         addr_mem[wr_ptr] <= push_addr_i;
         way_mem[wr_ptr]  <= push_way_i;
      end
   end

endmodule

`default_nettype wire

// ==== logic/icache_ctrl.sv ====
// Bank controller with the fetch pipeline register and the lookup, refill and wait FSM
`default_nettype none

module icache_ctrl import icache_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,

   // Fetch port
   input  wire logic        fetch_req_i,
   input  wire fetch_addr_t fetch_addr_i,
   output      logic        fetch_gnt_o,
   output      logic        fetch_rvalid_o,
   output      line_data_t  fetch_rdata_o,

   // Lookup result from the tag compare
   input  wire logic        hit_i,
   input  wire line_data_t  hit_line_i,

   // Memory read request
   output      logic        rd_req_o,
   output      set_idx_t    rd_set_o,
   output      fetch_addr_t lookup_addr_o,

   // Miss handling
   output      logic        save_valid_o,
   output      logic        buf_push_o,
   output      fetch_addr_t buf_addr_o,
   input  wire logic        buf_gnt_i,
   output      logic        advance_lfsr_o,
   input  wire logic        refill_done_i
);

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   // Pending request, its tag and data arrive one cycle after the read
   logic        req_q;
   fetch_addr_t addr_q;

   logic        load_pipe;
   logic        clear_pipe;

   // The pending address is compared against the read tags
   assign lookup_addr_o = addr_q;
   assign buf_addr_o    = addr_q;
   assign fetch_rdata_o = hit_line_i;

   //////////////////////////////////////////////////////////////////////
   // FSM next state and outputs
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d        = state_q;
      fetch_gnt_o    = 1'b0;
      fetch_rvalid_o = 1'b0;
      rd_req_o       = 1'b0;
      rd_set_o       = fetch_addr_i[LINE_OFFSET +: SET_BITS];
      save_valid_o   = 1'b0;
      buf_push_o     = 1'b0;
      advance_lfsr_o = 1'b0;
      load_pipe      = 1'b0;
      clear_pipe     = 1'b0;

      case (state_q)
         LOOKUP:
         begin
            // New fetch only with no pending one, or one that hits now
            fetch_gnt_o = fetch_req_i & (~req_q | hit_i);
            rd_req_o    = fetch_gnt_o;
            load_pipe   = fetch_gnt_o;

            if (req_q)
            begin
               if (hit_i)
               begin
                  fetch_rvalid_o = 1'b1;
                  clear_pipe     = ~fetch_gnt_o;
               end
               else
               begin
                  // Miss, keep the valid mask for the victim choice
                  save_valid_o = 1'b1;
                  state_d      = REQ_REFILL;
               end
            end
         end

         REQ_REFILL:
         begin
            buf_push_o = 1'b1;
            if (buf_gnt_i)
            begin
               advance_lfsr_o = 1'b1;
               state_d        = WAIT_REFILL;
            end
         end

         WAIT_REFILL:
         begin
            // Re-read the missed set once the line is written
            rd_set_o = addr_q[LINE_OFFSET +: SET_BITS];
            if (refill_done_i)
            begin
               rd_req_o = 1'b1;
               state_d  = LOOKUP;
            end
         end

         default:
         begin
            state_d = LOOKUP;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // State and pipeline registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= LOOKUP;
         req_q   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (load_pipe)
            req_q <= 1'b1;
         else if (clear_pipe)
            req_q <= 1'b0;
      end
   end

   // Address of the granted fetch
   always_ff @(posedge clk)
   begin
      if (load_pipe)
         addr_q <= fetch_addr_i;
   end

endmodule

`default_nettype wire

// ==== logic/icache_bank_top.sv ====
// Instruction-cache bank top, joins the controller FSM, tag compare, victim select and miss buffer
`default_nettype none

module icache_bank_top import icache_pkg::*;
#(
   parameter logic [7:0]  LFSR_SEED = 8'h00,
   parameter int unsigned BUF_DEPTH = 2
)
(
   input  wire logic                     clk,
   input  wire logic                     rst_n,

   // Fetch port from the core
   input  wire logic                     fetch_req_i,
   input  wire fetch_addr_t              fetch_addr_i,
   output      logic                     fetch_gnt_o,
   output      logic                     fetch_rvalid_o,
   output      line_data_t               fetch_rdata_o,

   // Read port of the external tag and data memories
   output      logic                     tag_req_o,
   output      logic                     data_req_o,
   output      set_idx_t                 rd_set_o,
   input  wire tag_entry_t [NB_WAYS-1:0] tag_rdata_i,
   input  wire line_data_t [NB_WAYS-1:0] data_rdata_i,

   // Refill port to the main cache controller
   output      logic                     refill_req_o,
   output      fetch_addr_t              refill_addr_o,
   output      way_mask_t                refill_way_o,
   input  wire logic                     refill_gnt_i,
   input  wire logic                     refill_done_i
);

   // Controller to datapath
   logic        rd_req;
   fetch_addr_t lookup_addr;
   logic        save_valid;
   logic        advance_lfsr;
   logic        buf_push;
   fetch_addr_t buf_addr;
   logic        buf_gnt;

   // Datapath to controller
   logic        hit;
   line_data_t  hit_line;
   way_mask_t   way_valid;
   way_mask_t   victim_way;

   // One read request drives both memories
   assign tag_req_o  = rd_req;
   assign data_req_o = rd_req;

   icache_ctrl u_ctrl
   (
      .clk            ( clk            ),
      .rst_n          ( rst_n          ),
      .fetch_req_i    ( fetch_req_i    ),
      .fetch_addr_i   ( fetch_addr_i   ),
      .hit_i          ( hit            ),
      .hit_line_i     ( hit_line       ),
      .buf_gnt_i      ( buf_gnt        ),
      .refill_done_i  ( refill_done_i  ),
      .fetch_gnt_o    ( fetch_gnt_o    ),
      .fetch_rvalid_o ( fetch_rvalid_o ),
      .fetch_rdata_o  ( fetch_rdata_o  ),
      .rd_req_o       ( rd_req         ),
      .rd_set_o       ( rd_set_o       ),
      .lookup_addr_o  ( lookup_addr    ),
      .save_valid_o   ( save_valid     ),
      .buf_push_o     ( buf_push       ),
      .buf_addr_o     ( buf_addr       ),
      .advance_lfsr_o ( advance_lfsr   )
   );

   tag_compare u_tag_compare
   (
      .lookup_addr_i ( lookup_addr  ),
      .tag_rdata_i   ( tag_rdata_i  ),
      .data_rdata_i  ( data_rdata_i ),
      .hit_o         ( hit          ),
      .hit_line_o    ( hit_line     ),
      .valid_o       ( way_valid    )
   );

   victim_select #( .LFSR_SEED ( LFSR_SEED ) ) u_victim_select
   (
      .clk            ( clk          ),
      .rst_n          ( rst_n        ),
      .valid_i        ( way_valid    ),
      .save_valid_i   ( save_valid   ),
      .advance_lfsr_i ( advance_lfsr ),
      .victim_way_o   ( victim_way   )
   );

   miss_buffer #( .BUF_DEPTH ( BUF_DEPTH ) ) u_miss_buffer
   (
      .clk         ( clk           ),
      .rst_n       ( rst_n         ),
      .push_i      ( buf_push      ),
      .push_addr_i ( buf_addr      ),
      .push_way_i  ( victim_way    ),
      .pop_gnt_i   ( refill_gnt_i  ),
      .push_gnt_o  ( buf_gnt       ),
      .req_o       ( refill_req_o  ),
      .addr_o      ( refill_addr_o ),
      .way_o       ( refill_way_o  )
   );

endmodule

`default_nettype wire

// ==== sim/icache_properties.sv ====
// Bound assertions on the fetch and refill handshakes and the one-hot refill way
`default_nettype none

module icache_properties import icache_pkg::*;
(
   input wire logic        clk,
   input wire logic        rst_n,
   input wire logic        fetch_req_i,
   input wire logic        fetch_gnt_o,
   input wire logic        fetch_rvalid_o,
   input wire logic        tag_req_o,
   input wire logic        refill_req_o,
   input wire fetch_addr_t refill_addr_o,
   input wire way_mask_t   refill_way_o,
   input wire logic        refill_gnt_i,
   input wire logic        refill_done_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int assert_fails = 0;

   // Handshake outputs quiet while reset is held
   a_reset_quiet: assert property (@(posedge clk)
      !rst_n |-> !fetch_gnt_o && !fetch_rvalid_o && !tag_req_o && !refill_req_o)
   else
   begin
      assert_fails++;
      $error("Handshake output high during reset");
   end

   // Refill request holds address and way until granted
   a_refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=>
         refill_req_o && $stable(refill_addr_o) && $stable(refill_way_o))
   else
   begin
      assert_fails++;
      $error("Refill request changed before its grant");
   end

   a_refill_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o |-> $onehot(refill_way_o))
   else
   begin
      assert_fails++;
      $error("Refill way is not one-hot");
   end

   // Every response lands one cycle after a grant or after refill done
   a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o |-> $past(fetch_req_i && fetch_gnt_o) || $past(refill_done_i))
   else
   begin
      assert_fails++;
      $error("Response not one cycle after its grant or refill done");
   end

endmodule

bind icache_bank_top icache_properties u_properties (.*);

`default_nettype wire

// ==== sim/icache_checker.sv ====
// Fetch and refill checker, compares responses and refill requests with the cache rules
`default_nettype none

module icache_checker import icache_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        fetch_req_i,
   input  wire fetch_addr_t fetch_addr_i,
   input  wire logic        fetch_gnt_i,
   input  wire logic        fetch_rvalid_i,
   input  wire line_data_t  fetch_rdata_i,
   input  wire logic        refill_req_i,
   input  wire fetch_addr_t refill_addr_i,
   input  wire way_mask_t   refill_way_i,
   input  wire logic        refill_gnt_i,
   input  wire logic        exp_hit_i,
   output      int          test_count_o,
   output      int          error_count_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Shadow of the ways filled so far in each set
   way_mask_t   filled [1 << SET_BITS];
   fetch_addr_t cur_addr;
   logic        cur_exp_hit;
   logic        pending;
   logic        test_bad;
   int          refills;
   int          cycle;
   int          grant_cycle;

   initial
   begin
      test_count_o  = 0;
      error_count_o = 0;
      pending       = 1'b0;
      test_bad      = 1'b0;
      refills       = 0;
      cycle         = 0;
      grant_cycle   = 0;
      foreach (filled[s])
         filled[s] = '0;
   end

   // Highest empty way, zero once the set is full
   function automatic way_mask_t highest_free_way(input way_mask_t used);
      way_mask_t way;
      way = '0;
      for (int w = NB_WAYS - 1; w >= 0; w--)
      begin
         if (!used[w] && way == '0)
            way[w] = 1'b1;
      end
      return way;
   endfunction

   task automatic flag_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      error_count_o++;
      test_bad = 1'b1;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Refill and response checks
   //////////////////////////////////////////////////////////////////////

   task automatic check_refill();
      set_idx_t  set_idx;
      way_mask_t exp_way;
      set_idx = refill_addr_i[LINE_OFFSET +: SET_BITS];
      exp_way = highest_free_way(filled[set_idx]);
      refills++;
      if (!pending)
      begin
         $display("Error at %0t ns: refill request with no fetch outstanding", $time);
         error_count_o++;
      end
      if (refill_addr_i !== cur_addr)
         flag_mismatch($sformatf("refill address %h, expected %h", refill_addr_i, cur_addr));
      if (!$onehot(refill_way_i))
         flag_mismatch($sformatf("refill way %b is not one-hot", refill_way_i));
      else if (exp_way != '0 && refill_way_i !== exp_way)
         flag_mismatch($sformatf("refill way %b, expected %b", refill_way_i, exp_way));
      filled[set_idx] = filled[set_idx] | refill_way_i;
   endtask

   task automatic check_response();
      line_data_t exp_data;
      if (!pending)
      begin
         $display("Error at %0t ns: response with no fetch outstanding", $time);
         error_count_o++;
         return;
      end
      // Line data is the fetch address repeated
      exp_data = {(LINE_WIDTH / ADDR_WIDTH){cur_addr}};
      if (fetch_rdata_i !== exp_data)
         flag_mismatch($sformatf("data %h, expected %h", fetch_rdata_i, exp_data));
      if (cur_exp_hit && refills != 0)
         flag_mismatch($sformatf("hit expected for %h, refill issued", cur_addr));
      if (!cur_exp_hit && refills != 1)
         flag_mismatch($sformatf("miss for %h expected one refill, saw %0d", cur_addr, refills));
      if (refills == 0 && cycle - grant_cycle != 1)
         flag_mismatch($sformatf("hit latency %0d cycles", cycle - grant_cycle));
      test_count_o++;
      $display("Fetch %0d at %h: %s, %s", test_count_o, cur_addr,
               (refills == 0) ? "hit" : "miss", test_bad ? "FAIL" : "ok");
      pending = 1'b0;
   endtask

   // Sampled on the edge, before any DUT register moves
   always @(posedge clk)
   begin
      cycle++;
      if (rst_n)
      begin
         if (refill_req_i && refill_gnt_i)
            check_refill();
         if (fetch_rvalid_i)
            check_response();
         if (fetch_req_i && fetch_gnt_i)
         begin
            cur_addr    = fetch_addr_i;
            cur_exp_hit = exp_hit_i;
            grant_cycle = cycle;
            refills     = 0;
            test_bad    = 1'b0;
            pending     = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
// Cache bank testbench with clock, reset, file-driven fetches, tag/data memories and refill model
`default_nettype none

module icache_tb import icache_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int    NB_SETS    = 1 << SET_BITS;
   localparam int    WAIT_LIMIT = 200;
   localparam string STIM_FILE  = "sim/icache_stimulus.txt";

   logic                     clk;
   logic                     rst_n;
   logic                     fetch_req;
   fetch_addr_t              fetch_addr;
   logic                     fetch_gnt;
   logic                     fetch_rvalid;
   line_data_t               fetch_rdata;
   logic                     tag_req;
   logic                     data_req;
   set_idx_t                 rd_set;
   tag_entry_t [NB_WAYS-1:0] tag_rdata;
   line_data_t [NB_WAYS-1:0] data_rdata;
   logic                     refill_req;
   fetch_addr_t              refill_addr;
   way_mask_t                refill_way;
   logic                     refill_gnt;
   logic                     refill_done;
   logic                     exp_hit;

   // External tag and data arrays, 16 sets by 4 ways
   tag_entry_t tag_mem  [NB_SETS][NB_WAYS];
   line_data_t data_mem [NB_SETS][NB_WAYS];

   integer     seed = 32'hf35c_afe9;
   int         test_count;
   int         error_count;
   logic       run_failed;

   icache_bank_top DUT
   (
      .clk            ( clk          ),
      .rst_n          ( rst_n        ),
      .fetch_req_i    ( fetch_req    ),
      .fetch_addr_i   ( fetch_addr   ),
      .fetch_gnt_o    ( fetch_gnt    ),
      .fetch_rvalid_o ( fetch_rvalid ),
      .fetch_rdata_o  ( fetch_rdata  ),
      .tag_req_o      ( tag_req      ),
      .data_req_o     ( data_req     ),
      .rd_set_o       ( rd_set       ),
      .tag_rdata_i    ( tag_rdata    ),
      .data_rdata_i   ( data_rdata   ),
      .refill_req_o   ( refill_req   ),
      .refill_addr_o  ( refill_addr  ),
      .refill_way_o   ( refill_way   ),
      .refill_gnt_i   ( refill_gnt   ),
      .refill_done_i  ( refill_done  )
   );

   icache_checker u_checker
   (
      .clk            ( clk          ),
      .rst_n          ( rst_n        ),
      .fetch_req_i    ( fetch_req    ),
      .fetch_addr_i   ( fetch_addr   ),
      .fetch_gnt_i    ( fetch_gnt    ),
      .fetch_rvalid_i ( fetch_rvalid ),
      .fetch_rdata_i  ( fetch_rdata  ),
      .refill_req_i   ( refill_req   ),
      .refill_addr_i  ( refill_addr  ),
      .refill_way_i   ( refill_way   ),
      .refill_gnt_i   ( refill_gnt   ),
      .exp_hit_i      ( exp_hit      ),
      .test_count_o   ( test_count   ),
      .error_count_o  ( error_count  )
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Memory and main-controller models
   //////////////////////////////////////////////////////////////////////

   // Tag and data answer one cycle after the read
   always @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (tag_req)
            tag_rdata[w] <= tag_mem[rd_set][w];
         if (data_req)
            data_rdata[w] <= data_mem[rd_set][w];
      end
   end

   // Refilled line holds its own address four times
   task automatic write_line(input fetch_addr_t addr, input way_mask_t way);
      set_idx_t set_idx;
      set_idx = addr[LINE_OFFSET +: SET_BITS];
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (way[w])
         begin
            tag_mem[set_idx][w]  <= {1'b1, addr[ADDR_WIDTH-1 -: TAG_BITS]};
            data_mem[set_idx][w] <= {(LINE_WIDTH / ADDR_WIDTH){addr}};
         end
      end
   endtask

   // Main controller, grants after a random delay, writes, then signals done
   initial
   begin : main_ctrl_model
      int          delay;
      fetch_addr_t addr;
      way_mask_t   way;
      forever
      begin
         @(posedge clk);
         if (rst_n && refill_req)
         begin
            // Grant stays low for at least two cycles
            delay = 2 + ($random(seed) & 7);
            for (int i = 0; i < delay; i++)
               @(posedge clk);
            refill_gnt <= 1'b1;
            @(posedge clk);
            refill_gnt <= 1'b0;
            addr = refill_addr;
            way  = refill_way;
            write_line(addr, way);
            @(posedge clk);
            refill_done <= 1'b1;
            @(posedge clk);
            refill_done <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Fetch driver
   //////////////////////////////////////////////////////////////////////

   task automatic run_fetch(input fetch_addr_t addr, input logic hit_flag, output logic done_ok);
      int waited;
      done_ok    = 1'b0;
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      exp_hit    <= hit_flag;
      waited     = 0;
      do
      begin
         @(posedge clk);
         waited++;
      end
      while (!fetch_gnt && waited < WAIT_LIMIT);
      fetch_req <= 1'b0;
      if (!fetch_gnt)
         $display("Fetch %h got no grant within %0d cycles", addr, WAIT_LIMIT);
      else
      begin
         waited = 0;
         do
         begin
            @(posedge clk);
            waited++;
         end
         while (!fetch_rvalid && waited < WAIT_LIMIT);
         if (!fetch_rvalid)
            $display("Fetch %h got no response within %0d cycles", addr, WAIT_LIMIT);
         else
            done_ok = 1'b1;
      end
   endtask

   initial
   begin : stimulus_flow
      int          fd;
      int          flag;
      string       line;
      fetch_addr_t addr;
      logic        done_ok;

      rst_n       = 1'b0;
      fetch_req   = 1'b0;
      fetch_addr  = '0;
      exp_hit     = 1'b0;
      tag_rdata   = '0;
      data_rdata  = '0;
      refill_gnt  = 1'b0;
      refill_done = 1'b0;
      run_failed  = 1'b0;
      // Empty tags, data filled with a set and way pattern
      for (int s = 0; s < NB_SETS; s++)
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            tag_mem[s][w]  = '0;
            data_mem[s][w] = {(LINE_WIDTH / ADDR_WIDTH){32'hbad0_0000 | (s << 4) | w}};
         end
      end

      fd = $fopen(STIM_FILE, "r");
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      if (fd == 0)
      begin
         $display("Cannot open stimulus file %s", STIM_FILE);
         run_failed = 1'b1;
      end

      // Comment and blank lines do not parse and are skipped
      while (!run_failed && fd != 0 && !$feof(fd))
      begin
         if ($fgets(line, fd) != 0 && $sscanf(line, "%h %d", addr, flag) == 2)
         begin
            run_fetch(addr, flag[0], done_ok);
            run_failed = ~done_ok;
         end
      end
      if (fd != 0)
         $fclose(fd);

      repeat (2) @(posedge clk);
      $display("Tests %0d, errors %0d, assertion failures %0d",
               test_count, error_count, DUT.u_properties.assert_fails);
      if (run_failed || error_count != 0 || test_count == 0 ||
          DUT.u_properties.assert_fails != 0)
         $display("Regression failed");
      else
         $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/icache_stimulus.txt ====
// Columns: fetch address (hex), expected result (1 hit, 0 miss)
// Set 1 once, set 5 filled over all ways then evicted, sets 10 and 15 last
00001010 0
00001010 1
00002050 0
00003050 0
00004050 0
00005050 0
00002050 1
00005050 1
00006050 0
00006050 1
0000a0a0 0
0000a0a0 1
000011f0 0
000011f0 1
00001010 1

// ==== verilog.f ====
logic/icache_pkg.sv
logic/tag_compare.sv
logic/victim_select.sv
logic/miss_buffer.sv
logic/icache_ctrl.sv
logic/icache_bank_top.sv
sim/icache_properties.sv
sim/icache_checker.sv
sim/icache_tb.sv
